// File: logic/blake_pkg.sv
/* shared BLAKE-256 types, round constants, sigma permutation table
   and the fixed padding words of the 80-byte header tail */
package blake_pkg;

   typedef logic [31:0] word_t;

   // working state v0..v15, index 0 is v0
   typedef word_t [15:0] state_t;

   typedef struct packed {
      state_t v;
      word_t  nonce;
      logic   valid;
   } stage_t;

   localparam int MIDSTATE_WORDS = 8;
   localparam int CHAIN_BITS = 384;

   localparam word_t CONST_TABLE [0:15] = '{
      32'h243F6A88, 32'h85A308D3, 32'h13198A2E, 32'h03707344,
      32'hA4093822, 32'h299F31D0, 32'h082EFA98, 32'hEC4E6C89,
      32'h452821E6, 32'h38D01377, 32'hBE5466CF, 32'h34E90C6C,
      32'hC0AC29B7, 32'hC97C50DD, 32'h3F84D5B5, 32'hB5470917
   };

   // message length in bits, 640 for an 80-byte header
   localparam word_t IV_LEN = 32'h0000_0280;

   // fixed tail words, all other message words past m3 are zero
   localparam word_t PAD_M4 = 32'h8000_0000;
   localparam word_t PAD_M13 = 32'h0000_0001;
   localparam word_t PAD_M15 = 32'h0000_0280;

   localparam logic [3:0] SIGMA_TABLE [0:9][0:15] = '{
      '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7,
        4'd8, 4'd9, 4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15},
      '{4'd14, 4'd10, 4'd4, 4'd8, 4'd9, 4'd15, 4'd13, 4'd6,
        4'd1, 4'd12, 4'd0, 4'd2, 4'd11, 4'd7, 4'd5, 4'd3},
      '{4'd11, 4'd8, 4'd12, 4'd0, 4'd5, 4'd2, 4'd15, 4'd13,
        4'd10, 4'd14, 4'd3, 4'd6, 4'd7, 4'd1, 4'd9, 4'd4},
      '{4'd7, 4'd9, 4'd3, 4'd1, 4'd13, 4'd12, 4'd11, 4'd14,
        4'd2, 4'd6, 4'd5, 4'd10, 4'd4, 4'd0, 4'd15, 4'd8},
      '{4'd9, 4'd0, 4'd5, 4'd7, 4'd2, 4'd4, 4'd10, 4'd15,
        4'd14, 4'd1, 4'd11, 4'd12, 4'd6, 4'd8, 4'd3, 4'd13},
      '{4'd2, 4'd12, 4'd6, 4'd10, 4'd0, 4'd11, 4'd8, 4'd3,
        4'd4, 4'd13, 4'd7, 4'd5, 4'd15, 4'd14, 4'd1, 4'd9},
      '{4'd12, 4'd5, 4'd1, 4'd15, 4'd14, 4'd13, 4'd4, 4'd10,
        4'd0, 4'd7, 4'd6, 4'd3, 4'd9, 4'd2, 4'd8, 4'd11},
      '{4'd13, 4'd11, 4'd7, 4'd14, 4'd12, 4'd1, 4'd3, 4'd9,
        4'd5, 4'd0, 4'd15, 4'd4, 4'd8, 4'd6, 4'd2, 4'd10},
      '{4'd6, 4'd15, 4'd14, 4'd9, 4'd11, 4'd3, 4'd0, 4'd8,
        4'd12, 4'd2, 4'd13, 4'd7, 4'd1, 4'd4, 4'd10, 4'd5},
      '{4'd10, 4'd2, 4'd8, 4'd4, 4'd7, 4'd6, 4'd1, 4'd5,
        4'd15, 4'd11, 4'd9, 4'd14, 4'd3, 4'd12, 4'd13, 4'd0}
   };

endpackage

// File: logic/blake_g.sv
/* BLAKE-256 G mixing function, combinational */
module blake_g (
   input  blake_pkg::word_t a_i,
   input  blake_pkg::word_t b_i,
   input  blake_pkg::word_t c_i,
   input  blake_pkg::word_t d_i,
   input  blake_pkg::word_t mx_i,
   input  blake_pkg::word_t my_i,
   output blake_pkg::word_t a_o,
   output blake_pkg::word_t b_o,
   output blake_pkg::word_t c_o,
   output blake_pkg::word_t d_o
);

   function automatic blake_pkg::word_t rotr(input blake_pkg::word_t x, input int n);
      return (x >> n) | (x << (32 - n));
   endfunction

   blake_pkg::word_t a1, b1, c1, d1;

   // mx/my already carry the xor with their round constant
   assign a1 = a_i + b_i + mx_i;
   assign d1 = rotr(d_i ^ a1, 16);
   assign c1 = c_i + d1;
   assign b1 = rotr(b_i ^ c1, 12);

   assign a_o = a1 + b1 + my_i;
   assign d_o = rotr(d1 ^ a_o, 8);
   assign c_o = c1 + d_o;
   assign b_o = rotr(b1 ^ c_o, 7);

endmodule

// File: logic/blake_round.sv
/* one BLAKE-256 round: column half and diagonal half,
   each followed by a register stage */
module blake_round #(
   parameter int ROUND = 0
) (
   input  logic                clk,
   input  logic                arst_n_i,
   input  blake_pkg::stage_t   stage_i,
   input  blake_pkg::word_t    hdr0_i,
   input  blake_pkg::word_t    hdr1_i,
   input  blake_pkg::word_t    hdr2_i,
   output blake_pkg::stage_t   stage_o
);

   localparam int R = ROUND % 10;

   blake_pkg::state_t m_col, m_diag;
   blake_pkg::state_t col_v, diag_v;
   blake_pkg::state_t col_q, diag_q;
   blake_pkg::word_t  nonce_col_q, nonce_diag_q;
   logic              valid_col_q, valid_diag_q;

   // message block, m3 is the nonce of whichever half is working on it
   always_comb begin
      m_col = '0;
      m_col[0] = hdr0_i;
      m_col[1] = hdr1_i;
      m_col[2] = hdr2_i;
      m_col[3] = stage_i.nonce;
      m_col[4] = blake_pkg::PAD_M4;
      m_col[13] = blake_pkg::PAD_M13;
      m_col[15] = blake_pkg::PAD_M15;
      m_diag = m_col;
      m_diag[3] = nonce_col_q;
   end

   for (genvar g = 0; g < 4; g++) begin : g_mix
      // columns (v0,v4,v8,v12) .. (v3,v7,v11,v15)
      blake_g i_col (
         .a_i  (stage_i.v[g]),
         .b_i  (stage_i.v[g+4]),
         .c_i  (stage_i.v[g+8]),
         .d_i  (stage_i.v[g+12]),
         .mx_i (m_col[blake_pkg::SIGMA_TABLE[R][2*g]]
                ^ blake_pkg::CONST_TABLE[blake_pkg::SIGMA_TABLE[R][2*g+1]]),
         .my_i (m_col[blake_pkg::SIGMA_TABLE[R][2*g+1]]
                ^ blake_pkg::CONST_TABLE[blake_pkg::SIGMA_TABLE[R][2*g]]),
         .a_o  (col_v[g]),
         .b_o  (col_v[g+4]),
         .c_o  (col_v[g+8]),
         .d_o  (col_v[g+12])
      );

      // diagonals (v0,v5,v10,v15) .. (v3,v4,v9,v14)
      blake_g i_diag (
         .a_i  (col_q[g]),
         .b_i  (col_q[4 + (g+1)%4]),
         .c_i  (col_q[8 + (g+2)%4]),
         .d_i  (col_q[12 + (g+3)%4]),
         .mx_i (m_diag[blake_pkg::SIGMA_TABLE[R][2*g+8]]
                ^ blake_pkg::CONST_TABLE[blake_pkg::SIGMA_TABLE[R][2*g+9]]),
         .my_i (m_diag[blake_pkg::SIGMA_TABLE[R][2*g+9]]
                ^ blake_pkg::CONST_TABLE[blake_pkg::SIGMA_TABLE[R][2*g+8]]),
         .a_o  (diag_v[g]),
         .b_o  (diag_v[4 + (g+1)%4]),
         .c_o  (diag_v[8 + (g+2)%4]),
         .d_o  (diag_v[12 + (g+3)%4])
      );
   end

   always_ff @(posedge clk) begin
      col_q <= col_v;
      nonce_col_q <= stage_i.nonce;
      diag_q <= diag_v;
      nonce_diag_q <= nonce_col_q;
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_col_q <= 1'b0;
         valid_diag_q <= 1'b0;
      end else begin
         valid_col_q <= stage_i.valid;
         valid_diag_q <= valid_col_q;
      end
   end

   assign stage_o = '{v: diag_q, nonce: nonce_diag_q, valid: valid_diag_q};

endmodule

// File: logic/blake_header_regs.sv
/* serial load chain for the midstate and header tail words */
module blake_header_regs (
   input  logic             clk,
   input  logic             arst_n_i,
   input  logic             shift_i,
   input  logic             din_i,
   output blake_pkg::word_t [blake_pkg::MIDSTATE_WORDS-1:0] midstate_o,
   output blake_pkg::word_t hdr0_o,
   output blake_pkg::word_t hdr1_o,
   output blake_pkg::word_t hdr2_o,
   output blake_pkg::word_t init_nonce_o
);

   logic [blake_pkg::CHAIN_BITS-1:0] chain_q;

   // msb first, the first bit in ends up in midstate word 7 bit 31
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         chain_q <= '0;
      end else if (shift_i) begin
         chain_q <= {chain_q[blake_pkg::CHAIN_BITS-2:0], din_i};
      end
   end

   assign midstate_o = chain_q[blake_pkg::CHAIN_BITS-1 -: blake_pkg::MIDSTATE_WORDS*32];

   // header tail, word 3 on top
   assign hdr0_o = chain_q[31:0];
   assign hdr1_o = chain_q[63:32];
   assign hdr2_o = chain_q[95:64];
   assign init_nonce_o = chain_q[127:96];

endmodule

// File: logic/blake_pipeline.sv
/* initial state setup and the unrolled chain of round stages */
module blake_pipeline #(
   parameter int NUM_ROUNDS = 8
) (
   input  logic              clk,
   input  logic              arst_n_i,
   input  blake_pkg::word_t  [blake_pkg::MIDSTATE_WORDS-1:0] midstate_i,
   input  blake_pkg::word_t  hdr0_i,
   input  blake_pkg::word_t  hdr1_i,
   input  blake_pkg::word_t  hdr2_i,
   input  blake_pkg::word_t  nonce_i,
   input  logic              nonce_valid_i,
   output blake_pkg::stage_t stage_o
);

   blake_pkg::state_t init_v;
   blake_pkg::stage_t stages [0:NUM_ROUNDS];

   // v0..v7 from midstate, v8..v15 from constants, t0 folded into v12/v13
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         init_v[i] = midstate_i[i];
         init_v[i+8] = blake_pkg::CONST_TABLE[i];
      end
      init_v[12] = blake_pkg::CONST_TABLE[4] ^ blake_pkg::IV_LEN;
      init_v[13] = blake_pkg::CONST_TABLE[5] ^ blake_pkg::IV_LEN;
   end

   assign stages[0] = '{v: init_v, nonce: nonce_i, valid: nonce_valid_i};

   for (genvar r = 0; r < NUM_ROUNDS; r++) begin : g_round
      blake_round #(
         .ROUND (r)
      ) i_round (
         .clk      (clk),
         .arst_n_i (arst_n_i),
         .stage_i  (stages[r]),
         .hdr0_i   (hdr0_i),
         .hdr1_i   (hdr1_i),
         .hdr2_i   (hdr2_i),
         .stage_o  (stages[r+1])
      );
   end

   assign stage_o = stages[NUM_ROUNDS];

endmodule

// File: logic/blake_match.sv
/* final hash word 7 and registered target compare */
module blake_match #(
   parameter int MATCH_BITS = 32
) (
   input  logic              clk,
   input  logic              arst_n_i,
   input  blake_pkg::stage_t stage_i,
   input  blake_pkg::word_t  mid7_i,
   output logic              gn_match_o
);

   blake_pkg::word_t hash7;
   logic             zero_low;

   // h7' = h7 ^ v7 ^ v15, salt is zero
   assign hash7 = mid7_i ^ stage_i.v[7] ^ stage_i.v[15];
   assign zero_low = (hash7[MATCH_BITS-1:0] == '0);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         gn_match_o <= 1'b0;
      end else begin
         gn_match_o <= stage_i.valid & zero_low;
      end
   end

endmodule

// File: logic/blake_miner_core.sv
/* BLAKE-256 midstate nonce search core: load chain, round pipeline, compare */
module blake_miner_core #(
   parameter int NUM_ROUNDS = 8,
   parameter int MATCH_BITS = 32
) (
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic        shift_i,
   input  logic        din_i,
   input  logic [31:0] nonce_i,
   input  logic        nonce_valid_i,
   output logic        gn_match_o,
   output logic [31:0] init_nonce_o
);

   blake_pkg::word_t [blake_pkg::MIDSTATE_WORDS-1:0] midstate;
   blake_pkg::word_t  hdr0, hdr1, hdr2;
   blake_pkg::stage_t last_stage;

   blake_header_regs i_header_regs (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .shift_i      (shift_i),
      .din_i        (din_i),
      .midstate_o   (midstate),
      .hdr0_o       (hdr0),
      .hdr1_o       (hdr1),
      .hdr2_o       (hdr2),
      .init_nonce_o (init_nonce_o)
   );

   blake_pipeline #(
      .NUM_ROUNDS (NUM_ROUNDS)
   ) i_pipeline (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .midstate_i    (midstate),
      .hdr0_i        (hdr0),
      .hdr1_i        (hdr1),
      .hdr2_i        (hdr2),
      .nonce_i       (nonce_i),
      .nonce_valid_i (nonce_valid_i),
      .stage_o       (last_stage)
   );

   blake_match #(
      .MATCH_BITS (MATCH_BITS)
   ) i_match (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .stage_i    (last_stage),
      .mid7_i     (midstate[7]),
      .gn_match_o (gn_match_o)
   );

endmodule

// File: sim/blake_miner_core_props.sv
/* bound assertions on reset, valid alignment and the load chain */
module blake_miner_core_props #(
   parameter int NUM_ROUNDS = 8
) (
   input logic        clk,
   input logic        arst_n_i,
   input logic        shift_i,
   input logic        nonce_valid_i,
   input logic        gn_match_i,
   input logic [31:0] init_nonce_i
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int LATENCY = 2 * NUM_ROUNDS + 1;

   int fails = 0;

   a_reset_low: assert property (@(posedge clk) !arst_n_i |-> !gn_match_i)
      else begin
         $error("gn_match_o high while in reset");
         fails++;
      end

   // a slot that entered invalid never reports a match
   a_valid_gate: assert property (@(posedge clk) disable iff (!arst_n_i)
      !$past(nonce_valid_i, LATENCY) |-> !gn_match_i)
      else begin
         $error("gn_match_o high for an invalid slot");
         fails++;
      end

   a_nonce_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      (init_nonce_i != $past(init_nonce_i)) |-> $past(shift_i))
      else begin
         $error("init_nonce_o changed without a shift");
         fails++;
      end

endmodule

bind blake_miner_core blake_miner_core_props #(
   .NUM_ROUNDS (NUM_ROUNDS)
) i_props (
   .clk           (clk),
   .arst_n_i      (arst_n_i),
   .shift_i       (shift_i),
   .nonce_valid_i (nonce_valid_i),
   .gn_match_i    (gn_match_o),
   .init_nonce_i  (init_nonce_o)
);

// File: sim/blake_miner_core_tb.sv
/* testbench for the BLAKE-256 nonce search core
   reference model, match scoreboard and directed tests */
module blake_miner_core_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_ROUNDS = 8;
   localparam int MATCH_BITS = 8;
   localparam int LATENCY = 2 * NUM_ROUNDS + 1;
   localparam int MAX_CYCLES = 3000;

   logic        clk = 1'b0;
   logic        arst_n_i, shift_i, din_i, nonce_valid_i;
   logic [31:0] nonce_i;
   logic        gn_match_o;
   logic [31:0] init_nonce_o;

   logic [blake_pkg::CHAIN_BITS-1:0] chain;
   // a nonce that the model says matches the loaded header
   blake_pkg::word_t hit_nonce;
   // expected match bit of each of the last LATENCY driven slots
   logic expect_q [$];
   int   errors = 0;
   int   checks = 0;
   int   cycles = 0;
   int   predicted = 0;

   blake_miner_core #(
      .NUM_ROUNDS (NUM_ROUNDS),
      .MATCH_BITS (MATCH_BITS)
   ) i_dut (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .shift_i       (shift_i),
      .din_i         (din_i),
      .nonce_i       (nonce_i),
      .nonce_valid_i (nonce_valid_i),
      .gn_match_o    (gn_match_o),
      .init_nonce_o  (init_nonce_o)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   function automatic blake_pkg::word_t rotr(blake_pkg::word_t x, int n);
      return (x >> n) | (x << (32 - n));
   endfunction

   // reduced-round compression, returns final hash word 7
   function automatic blake_pkg::word_t ref_hash7(logic [383:0] ch, blake_pkg::word_t nonce);
      blake_pkg::word_t v [16];
      blake_pkg::word_t m [16];
      int               a, b, c, d, k;
      logic [3:0]       sx, sy;
      for (int i = 0; i < 16; i++) begin
         m[i] = '0;
         v[i] = (i < 8) ? ch[128 + 32*i +: 32] : blake_pkg::CONST_TABLE[i-8];
      end
      v[12] ^= blake_pkg::IV_LEN;
      v[13] ^= blake_pkg::IV_LEN;
      m[0] = ch[31:0];
      m[1] = ch[63:32];
      m[2] = ch[95:64];
      m[3] = nonce;
      m[4] = blake_pkg::PAD_M4;
      m[13] = blake_pkg::PAD_M13;
      m[15] = blake_pkg::PAD_M15;
      for (int r = 0; r < NUM_ROUNDS; r++) begin
         // j 0..3 columns, 4..7 diagonals
         for (int j = 0; j < 8; j++) begin
            k = j % 4;
            a = k;
            b = (j < 4) ? k + 4 : 4 + (k + 1) % 4;
            c = (j < 4) ? k + 8 : 8 + (k + 2) % 4;
            d = (j < 4) ? k + 12 : 12 + (k + 3) % 4;
            sx = blake_pkg::SIGMA_TABLE[r % 10][2*j];
            sy = blake_pkg::SIGMA_TABLE[r % 10][2*j+1];
            v[a] = v[a] + v[b] + (m[sx] ^ blake_pkg::CONST_TABLE[sy]);
            v[d] = rotr(v[d] ^ v[a], 16);
            v[c] = v[c] + v[d];
            v[b] = rotr(v[b] ^ v[c], 12);
            v[a] = v[a] + v[b] + (m[sy] ^ blake_pkg::CONST_TABLE[sx]);
            v[d] = rotr(v[d] ^ v[a], 8);
            v[c] = v[c] + v[d];
            v[b] = rotr(v[b] ^ v[c], 7);
         end
      end
      return ch[383:352] ^ v[7] ^ v[15];
   endfunction

   task automatic search_hit_nonce();
      blake_pkg::word_t n;
      blake_pkg::word_t h;
      for (int i = 0; i < 65536; i++) begin
         n = $urandom;
         h = ref_hash7(chain, n);
         if (h[MATCH_BITS-1:0] == '0) begin
            hit_nonce = n;
            return;
         end
      end
      errors++;
      $display("no matching nonce found for the loaded header");
   endtask

   // one slot per falling edge, checks the slot driven LATENCY edges back
   task automatic drive_cycle(logic valid, blake_pkg::word_t nonce);
      blake_pkg::word_t h;
      logic             expected;
      @(negedge clk);
      if (expect_q.size() == LATENCY) begin
         expected = expect_q.pop_front();
         check_value("gn_match_o", 32'(gn_match_o), 32'(expected));
      end
      h = ref_hash7(chain, nonce);
      expected = valid && (h[MATCH_BITS-1:0] == '0);
      if (expected)
         predicted++;
      nonce_valid_i = valid;
      nonce_i = nonce;
      expect_q.push_back(expected);
   endtask

   task automatic drain_pipeline();
      repeat (LATENCY) drive_cycle(1'b0, $urandom);
      // the trailing idle slots carry no result
      expect_q.delete();
   endtask

   // idle slots carrying a hit nonce must still report nothing
   task automatic check_reset_state();
      check_value("gn_match_o", 32'(gn_match_o), 32'(0));
      check_value("init_nonce_o", init_nonce_o, '0);
      repeat (2 * LATENCY) drive_cycle(1'b0, hit_nonce);
      drain_pipeline();
   endtask

   // msb first, then init_nonce_o must show header word 3
   task automatic load_chain();
      logic [383:0] bits;
      for (int i = 0; i < 12; i++)
         bits[32*i +: 32] = $urandom;
      for (int i = blake_pkg::CHAIN_BITS - 1; i >= 0; i--) begin
         @(negedge clk);
         shift_i = 1'b1;
         din_i = bits[i];
      end
      @(negedge clk);
      shift_i = 1'b0;
      din_i = 1'b0;
      chain = bits;
      check_value("init_nonce_o", init_nonce_o, bits[127:96]);
      search_hit_nonce();
   endtask

   task automatic send_single_nonce();
      drive_cycle(1'b1, hit_nonce);
      drain_pipeline();
   endtask

   task automatic stream_nonces(int count, bit gaps);
      blake_pkg::word_t nonce;
      logic             valid;
      for (int i = 0; i < count; i++) begin
         // known hit every 16 slots, some land on idle slots in gap mode
         nonce = (i % 16 == 5) ? hit_nonce : blake_pkg::word_t'($urandom);
         valid = !gaps || (i % 3 != 2);
         drive_cycle(valid, nonce);
      end
      drain_pipeline();
   endtask

   task automatic reload_and_stream();
      load_chain();
      stream_nonces(200, 1'b0);
   endtask

   initial begin
      void'($urandom(32'h2f0e));
      arst_n_i = 1'b0;
      shift_i = 1'b0;
      din_i = 1'b0;
      nonce_valid_i = 1'b0;
      nonce_i = '0;
      chain = '0;
      repeat (10) @(negedge clk);
      arst_n_i = 1'b1;
      search_hit_nonce();
      check_reset_state();
      load_chain();
      send_single_nonce();
      stream_nonces(600, 1'b0);
      stream_nonces(160, 1'b1);
      reload_and_stream();
      $display("%0d checks, %0d errors, %0d assertion failures, %0d predicted matches",
               checks, errors, i_dut.i_props.fails, predicted);
      if (errors == 0 && i_dut.i_props.fails == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: blake_miner_core.f
logic/blake_pkg.sv
logic/blake_g.sv
logic/blake_round.sv
logic/blake_header_regs.sv
logic/blake_pipeline.sv
logic/blake_match.sv
logic/blake_miner_core.sv
sim/blake_miner_core_props.sv
sim/blake_miner_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f blake_miner_core.f --top-module blake_miner_core_tb -Mdir obj_dir || exit 1
out=$(./obj_dir/Vblake_miner_core_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'ALL CHECKS PASSED' && exit 0 || exit 1
